// File: logic/alu_op_pkg.sv
`default_nettype none

package alu_op_pkg;

  localparam int data_w = 64;

  // operation codes as seen on the op input
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_mov  = 4'd5,
    op_zxt  = 4'd6,
    op_sxt  = 4'd7,
    op_cmov = 4'd8,
    op_cset = 4'd9,
    op_lahf = 4'd10,
    op_sahf = 4'd11
  } alu_op_t;

  typedef enum logic [1:0] {
    w8  = 2'd0,
    w16 = 2'd1,
    w32 = 2'd2,
    w64 = 2'd3
  } width_t;

  // unit that owns the result
  typedef enum logic [1:0] {
    cls_arith = 2'd0,
    cls_logic = 2'd1,
    cls_move  = 2'd2,
    cls_flag  = 2'd3
  } op_class_t;

  // ones in the low w bits
  function automatic logic [data_w-1:0] width_mask(width_t w);
    logic [data_w-1:0] m;
    case (w)
      w8:      m = 64'h0000_0000_0000_00ff;
      w16:     m = 64'h0000_0000_0000_ffff;
      w32:     m = 64'h0000_0000_ffff_ffff;
      default: m = 64'hffff_ffff_ffff_ffff;
    endcase
    return m;
  endfunction

endpackage

`default_nettype wire

// File: logic/alu_flag_pkg.sv
`default_nettype none

package alu_flag_pkg;

  localparam int flags_w = 6;

  // flag word is {c,o,a,s,z,p}
  localparam int flag_c = 5;
  localparam int flag_o = 4;
  localparam int flag_a = 3;
  localparam int flag_s = 2;
  localparam int flag_z = 1;
  localparam int flag_p = 0;

  typedef enum logic [4:0] {
    z           = 5'd0,
    nz          = 5'd1,
    s           = 5'd2,
    ns          = 5'd3,
    ugt         = 5'd4,
    ule         = 5'd5,
    uge         = 5'd6,
    ult         = 5'd7,
    sgt         = 5'd8,
    sle         = 5'd9,
    sge         = 5'd10,
    slt         = 5'd11,
    o           = 5'd12,
    no          = 5'd13,
    p           = 5'd14,
    np          = 5'd15,
    always_true = 5'd16,
    never       = 5'd17
  } cond_t;

endpackage

`default_nettype wire

// File: logic/alu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 in_valid,
  input  alu_op_pkg::alu_op_t                 op,
  input  alu_op_pkg::width_t                  width,
  input  alu_flag_pkg::cond_t                 cond,
  input  wire [alu_op_pkg::data_w-1:0]        src_a,
  input  wire [alu_op_pkg::data_w-1:0]        src_b,
  input  wire [alu_flag_pkg::flags_w-1:0]     flags_in,
  input  wire                                 keep_flags,
  output logic                                d_valid,
  output alu_op_pkg::alu_op_t                 d_op,
  output alu_op_pkg::op_class_t               d_class,
  output alu_op_pkg::width_t                  d_width,
  output alu_flag_pkg::cond_t                 d_cond,
  output logic [alu_op_pkg::data_w-1:0]       d_a,
  output logic [alu_op_pkg::data_w-1:0]       d_b,
  output logic [alu_flag_pkg::flags_w-1:0]    d_flags,
  output logic                                d_wr_flags
);

  alu_op_pkg::op_class_t cls;
  logic                  wr_flags;

  always_comb begin
    case (op)
      alu_op_pkg::op_add, alu_op_pkg::op_sub: cls = alu_op_pkg::cls_arith;
      alu_op_pkg::op_and, alu_op_pkg::op_or,
      alu_op_pkg::op_xor:                     cls = alu_op_pkg::cls_logic;
      alu_op_pkg::op_sahf:                    cls = alu_op_pkg::cls_flag;
      default:                                cls = alu_op_pkg::cls_move;
    endcase
  end

  // moves, extensions, cmov/cset and lahf leave the flags alone
  assign wr_flags = (cls != alu_op_pkg::cls_move) && !keep_flags;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_valid    <= 1'b0;
      d_wr_flags <= 1'b0;
    end else begin
      d_valid    <= in_valid;
      d_wr_flags <= wr_flags;
    end
  end

  always_ff @(posedge clk) begin
    d_op    <= op;
    d_class <= cls;
    d_width <= width;
    d_cond  <= cond;
    d_a     <= src_a;
    d_b     <= src_b;
    d_flags <= flags_in; // flags travel with their item
  end

  a_known_op : assert property (@(posedge clk) disable iff (rst)
    d_valid |-> (!$isunknown(d_op) &&
                 d_op inside {[alu_op_pkg::op_add : alu_op_pkg::op_sahf]}));

endmodule

`default_nettype wire

// File: logic/alu_cond.sv
`timescale 1ns/1ps
`default_nettype none

module alu_cond (
  input  wire [alu_flag_pkg::flags_w-1:0] flags,
  input  alu_flag_pkg::cond_t             cond,
  output logic                            taken
);

  logic c, o, s, z, p;

  assign c = flags[alu_flag_pkg::flag_c];
  assign o = flags[alu_flag_pkg::flag_o];
  assign s = flags[alu_flag_pkg::flag_s];
  assign z = flags[alu_flag_pkg::flag_z];
  assign p = flags[alu_flag_pkg::flag_p];

  always_comb begin
    case (cond)
      alu_flag_pkg::z:     taken = z;
      alu_flag_pkg::nz:    taken = !z;
      alu_flag_pkg::s:     taken = s;
      alu_flag_pkg::ns:    taken = !s;
      alu_flag_pkg::ugt:   taken = !(c || z);
      alu_flag_pkg::ule:   taken = c || z;
      alu_flag_pkg::uge:   taken = !c;
      alu_flag_pkg::ult:   taken = c;
      alu_flag_pkg::sgt:   taken = !((s ^ o) || z);
      alu_flag_pkg::sle:   taken = (s ^ o) || z;
      alu_flag_pkg::sge:   taken = !(s ^ o);
      alu_flag_pkg::slt:   taken = s ^ o;
      alu_flag_pkg::o:     taken = o;
      alu_flag_pkg::no:    taken = !o;
      alu_flag_pkg::p:     taken = p;
      alu_flag_pkg::np:    taken = !p;
      alu_flag_pkg::never: taken = 1'b0;
      default:             taken = 1'b1; // always
    endcase
  end

endmodule

`default_nettype wire

// File: logic/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 d_valid,
  input  alu_op_pkg::alu_op_t                 d_op,
  input  alu_op_pkg::op_class_t               d_class,
  input  alu_op_pkg::width_t                  d_width,
  input  alu_flag_pkg::cond_t                 d_cond,
  input  wire [alu_op_pkg::data_w-1:0]        d_a,
  input  wire [alu_op_pkg::data_w-1:0]        d_b,
  input  wire [alu_flag_pkg::flags_w-1:0]     d_flags,
  input  wire                                 d_wr_flags,
  output logic                                e_valid,
  output alu_op_pkg::alu_op_t                 e_op,
  output alu_op_pkg::width_t                  e_width,
  output logic [alu_op_pkg::data_w-1:0]       e_res,
  output logic                                e_carry,
  output logic                                e_aux,
  output logic                                e_sign_a,
  output logic                                e_sign_b,
  output logic [alu_flag_pkg::flags_w-1:0]    e_flags,
  output logic                                e_wr_flags
);

  localparam int dw = alu_op_pkg::data_w;

  logic          is_sub;
  logic [dw-1:0] b_eff;
  logic [dw:0]   sum;
  logic [dw:0]   cvec;     // carry into each bit
  logic [dw-1:0] mask;
  logic [dw-1:0] sxt_val;
  logic          carry_w;
  logic          sign_a;
  logic          sign_b;
  logic          taken;
  logic [dw-1:0] res;

  alu_cond alu_cond_inst (
    .flags (d_flags),
    .cond  (d_cond),
    .taken (taken)
  );

  assign is_sub = (d_op == alu_op_pkg::op_sub);
  assign b_eff  = is_sub ? ~d_b : d_b;
  assign sum    = {1'b0, d_a} + {1'b0, b_eff} + {{dw{1'b0}}, is_sub};
  assign cvec   = sum ^ {1'b0, d_a} ^ {1'b0, b_eff};
  assign mask   = alu_op_pkg::width_mask(d_width);

  always_comb begin
    case (d_width)
      alu_op_pkg::w8: begin
        carry_w = cvec[8];
        sign_a  = d_a[7];
        sign_b  = d_b[7];
        sxt_val = {{56{d_b[7]}}, d_b[7:0]};
      end
      alu_op_pkg::w16: begin
        carry_w = cvec[16];
        sign_a  = d_a[15];
        sign_b  = d_b[15];
        sxt_val = {{48{d_b[15]}}, d_b[15:0]};
      end
      alu_op_pkg::w32: begin
        carry_w = cvec[32];
        sign_a  = d_a[31];
        sign_b  = d_b[31];
        sxt_val = {{32{d_b[31]}}, d_b[31:0]};
      end
      default: begin
        carry_w = cvec[64];
        sign_a  = d_a[63];
        sign_b  = d_b[63];
        sxt_val = d_b;
      end
    endcase
  end

  always_comb begin
    case (d_class)
      alu_op_pkg::cls_arith: res = sum[dw-1:0] & mask;
      alu_op_pkg::cls_logic: begin
        case (d_op)
          alu_op_pkg::op_and: res = d_a & d_b & mask;
          alu_op_pkg::op_or:  res = (d_a | d_b) & mask;
          default:            res = (d_a ^ d_b) & mask;
        endcase
      end
      alu_op_pkg::cls_move: begin
        case (d_op)
          alu_op_pkg::op_sxt:  res = sxt_val;
          alu_op_pkg::op_cmov: res = taken ? d_b : d_a; // full width either way
          alu_op_pkg::op_cset: res = {{(dw-1){1'b0}}, taken};
          alu_op_pkg::op_lahf: res = {{(dw-alu_flag_pkg::flags_w){1'b0}}, d_flags};
          default:             res = d_b & mask; // mov, zxt
        endcase
      end
      default: res = '0; // sahf
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      e_valid    <= 1'b0;
      e_wr_flags <= 1'b0;
    end else begin
      e_valid    <= d_valid;
      e_wr_flags <= d_wr_flags;
    end
  end

  always_ff @(posedge clk) begin
    e_op     <= d_op;
    e_width  <= d_width;
    e_res    <= res;
    e_carry  <= carry_w;
    e_aux    <= cvec[4];
    e_sign_a <= sign_a;
    e_sign_b <= sign_b;
    // sahf takes its flag word from src_a
    e_flags  <= (d_op == alu_op_pkg::op_sahf) ? d_a[alu_flag_pkg::flags_w-1:0] : d_flags;
  end

  a_upper_zero : assert property (@(posedge clk) disable iff (rst)
    (e_valid && e_op inside {[alu_op_pkg::op_add : alu_op_pkg::op_xor]})
      |-> ((e_res & ~alu_op_pkg::width_mask(e_width)) == '0));

endmodule

`default_nettype wire

// File: logic/alu_result.sv
`timescale 1ns/1ps
`default_nettype none

module alu_result (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 e_valid,
  input  alu_op_pkg::alu_op_t                 e_op,
  input  alu_op_pkg::width_t                  e_width,
  input  wire [alu_op_pkg::data_w-1:0]        e_res,
  input  wire                                 e_carry,
  input  wire                                 e_aux,
  input  wire                                 e_sign_a,
  input  wire                                 e_sign_b,
  input  wire [alu_flag_pkg::flags_w-1:0]     e_flags,
  input  wire                                 e_wr_flags,
  output logic                                out_valid,
  output logic [alu_op_pkg::data_w-1:0]       result,
  output logic [alu_flag_pkg::flags_w-1:0]    flags_out,
  output logic                                flags_wr
);

  logic                             is_sub;
  logic                             sign_r;
  logic                             zero_r;
  logic                             par_r;
  logic                             ovf;
  logic [alu_flag_pkg::flags_w-1:0] fw;

  assign is_sub = (e_op == alu_op_pkg::op_sub);

  always_comb begin
    case (e_width)
      alu_op_pkg::w8:  sign_r = e_res[7];
      alu_op_pkg::w16: sign_r = e_res[15];
      alu_op_pkg::w32: sign_r = e_res[31];
      default:         sign_r = e_res[63];
    endcase
  end

  assign zero_r = ((e_res & alu_op_pkg::width_mask(e_width)) == '0);
  assign par_r  = ~^e_res[7:0]; // even parity of low byte

  // sub flips the second operand sign
  assign ovf = ((e_sign_a ^ e_sign_b ^ is_sub) == 1'b0) && (sign_r != e_sign_a);

  always_comb begin
    fw = e_flags; // moves, lahf, sahf
    case (e_op)
      alu_op_pkg::op_add, alu_op_pkg::op_sub: begin
        fw[alu_flag_pkg::flag_c] = e_carry ^ is_sub; // borrow on sub
        fw[alu_flag_pkg::flag_o] = ovf;
        fw[alu_flag_pkg::flag_a] = e_aux ^ is_sub;
        fw[alu_flag_pkg::flag_s] = sign_r;
        fw[alu_flag_pkg::flag_z] = zero_r;
        fw[alu_flag_pkg::flag_p] = par_r;
      end
      alu_op_pkg::op_and, alu_op_pkg::op_or, alu_op_pkg::op_xor: begin
        fw[alu_flag_pkg::flag_c] = 1'b0;
        fw[alu_flag_pkg::flag_o] = 1'b0;
        fw[alu_flag_pkg::flag_a] = 1'b0;
        fw[alu_flag_pkg::flag_s] = sign_r;
        fw[alu_flag_pkg::flag_z] = zero_r;
        fw[alu_flag_pkg::flag_p] = par_r;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      flags_wr  <= 1'b0;
    end else begin
      out_valid <= e_valid;
      flags_wr  <= e_valid && e_wr_flags;
    end
  end

  always_ff @(posedge clk) begin
    result    <= e_res;
    flags_out <= fw;
  end

  a_wr_valid : assert property (@(posedge clk) disable iff (rst)
    flags_wr |-> out_valid);

endmodule

`default_nettype wire

// File: logic/alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 in_valid,
  input  alu_op_pkg::alu_op_t                 op,
  input  alu_op_pkg::width_t                  width,
  input  alu_flag_pkg::cond_t                 cond,
  input  wire [alu_op_pkg::data_w-1:0]        src_a,
  input  wire [alu_op_pkg::data_w-1:0]        src_b,
  input  wire [alu_flag_pkg::flags_w-1:0]     flags_in,
  input  wire                                 keep_flags,
  output logic                                out_valid,
  output logic [alu_op_pkg::data_w-1:0]       result,
  output logic [alu_flag_pkg::flags_w-1:0]    flags_out,
  output logic                                flags_wr
);

  // decode to execute
  logic                             d_valid;
  alu_op_pkg::alu_op_t              d_op;
  alu_op_pkg::op_class_t            d_class;
  alu_op_pkg::width_t               d_width;
  alu_flag_pkg::cond_t              d_cond;
  logic [alu_op_pkg::data_w-1:0]    d_a;
  logic [alu_op_pkg::data_w-1:0]    d_b;
  logic [alu_flag_pkg::flags_w-1:0] d_flags;
  logic                             d_wr_flags;

  // execute to result
  logic                             e_valid;
  alu_op_pkg::alu_op_t              e_op;
  alu_op_pkg::width_t               e_width;
  logic [alu_op_pkg::data_w-1:0]    e_res;
  logic                             e_carry;
  logic                             e_aux;
  logic                             e_sign_a;
  logic                             e_sign_b;
  logic [alu_flag_pkg::flags_w-1:0] e_flags;
  logic                             e_wr_flags;

  alu_decode alu_decode_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .op         (op),
    .width      (width),
    .cond       (cond),
    .src_a      (src_a),
    .src_b      (src_b),
    .flags_in   (flags_in),
    .keep_flags (keep_flags),
    .d_valid    (d_valid),
    .d_op       (d_op),
    .d_class    (d_class),
    .d_width    (d_width),
    .d_cond     (d_cond),
    .d_a        (d_a),
    .d_b        (d_b),
    .d_flags    (d_flags),
    .d_wr_flags (d_wr_flags)
  );

  alu_execute alu_execute_inst (
    .clk        (clk),
    .rst        (rst),
    .d_valid    (d_valid),
    .d_op       (d_op),
    .d_class    (d_class),
    .d_width    (d_width),
    .d_cond     (d_cond),
    .d_a        (d_a),
    .d_b        (d_b),
    .d_flags    (d_flags),
    .d_wr_flags (d_wr_flags),
    .e_valid    (e_valid),
    .e_op       (e_op),
    .e_width    (e_width),
    .e_res      (e_res),
    .e_carry    (e_carry),
    .e_aux      (e_aux),
    .e_sign_a   (e_sign_a),
    .e_sign_b   (e_sign_b),
    .e_flags    (e_flags),
    .e_wr_flags (e_wr_flags)
  );

  alu_result alu_result_inst (
    .clk        (clk),
    .rst        (rst),
    .e_valid    (e_valid),
    .e_op       (e_op),
    .e_width    (e_width),
    .e_res      (e_res),
    .e_carry    (e_carry),
    .e_aux      (e_aux),
    .e_sign_a   (e_sign_a),
    .e_sign_b   (e_sign_b),
    .e_flags    (e_flags),
    .e_wr_flags (e_wr_flags),
    .out_valid  (out_valid),
    .result     (result),
    .flags_out  (flags_out),
    .flags_wr   (flags_wr)
  );

endmodule

`default_nettype wire

// File: tests/alu_tests.svh
`ifndef alu_tests_svh
`define alu_tests_svh

// empty pipeline first, then a single item
task automatic idle_and_latency();
  repeat (6) begin
    @(negedge clk);
    assert (out_valid === 1'b0 && flags_wr === 1'b0) else begin
      $display("out_valid or flags_wr high while the pipeline is empty");
      other_errs++;
    end
  end
  send_item(alu_op_pkg::op_add, alu_op_pkg::w64, alu_flag_pkg::z, 64'd2, 64'd3, 6'h00, 1'b0);
  drain();
endtask

task automatic add_sub_corners();
  logic [dw-1:0]       m;
  logic [dw-1:0]       sbit;
  logic [dw-1:0]       ca [n_corner];
  logic [dw-1:0]       cb [n_corner];
  alu_op_pkg::alu_op_t op_i;
  alu_op_pkg::width_t  w_i;
  for (int wi = 0; wi < 4; wi++) begin
    w_i = alu_op_pkg::width_t'(wi);
    m = low_ones(width_bits(w_i));
    sbit = (m >> 1) + 64'd1;
    ca[0] = m;  // wraps to zero on add
    cb[0] = 64'd1;
    ca[1] = sbit - 64'd1; // max positive plus one
    cb[1] = 64'd1;
    ca[2] = 64'd0;  // borrow
    cb[2] = 64'd1;
    ca[3] = sbit;  // min negative minus one
    cb[3] = 64'd1;
    ca[4] = 64'd5;
    cb[4] = 64'd5;
    ca[5] = 64'hf;  // nibble carry
    cb[5] = 64'd1;
    ca[6] = 64'd3;
    cb[6] = 64'd0;
    for (int oi = 0; oi < 2; oi++) begin
      if (oi == 0) op_i = alu_op_pkg::op_add;
      else op_i = alu_op_pkg::op_sub;
      for (int k = 0; k < n_corner; k++) begin
        send_item(op_i, w_i, alu_flag_pkg::z, ca[k], cb[k], rand_flags(), 1'b0);
      end
      for (int k = 0; k < n_rand_arith; k++) begin
        send_item(op_i, w_i, alu_flag_pkg::z, rand64(), rand64(), rand_flags(), 1'b0);
      end
    end
  end
  drain();
endtask

task automatic logic_ops();
  alu_op_pkg::alu_op_t lops [3];
  lops[0] = alu_op_pkg::op_and;
  lops[1] = alu_op_pkg::op_or;
  lops[2] = alu_op_pkg::op_xor;
  for (int wi = 0; wi < 4; wi++) begin
    for (int oi = 0; oi < 3; oi++) begin
      for (int k = 0; k < n_rand_logic; k++) begin
        // c, o and a set on the way in for the first one
        send_item(lops[oi], alu_op_pkg::width_t'(wi), alu_flag_pkg::z, rand64(), rand64(),
                  (k == 0) ? 6'h38 : rand_flags(), 1'b0);
      end
    end
  end
  for (int oi = 0; oi < 3; oi++) begin
    send_item(lops[oi], alu_op_pkg::w32, alu_flag_pkg::z, rand64(), rand64(), 6'h38, 1'b1);
  end
  drain();
endtask

task automatic moves_and_extends();
  alu_op_pkg::alu_op_t mops [3];
  alu_op_pkg::width_t  w_i;
  logic [dw-1:0]       sbit;
  logic [dw-1:0]       v;
  mops[0] = alu_op_pkg::op_mov;
  mops[1] = alu_op_pkg::op_zxt;
  mops[2] = alu_op_pkg::op_sxt;
  for (int wi = 0; wi < 4; wi++) begin
    w_i = alu_op_pkg::width_t'(wi);
    sbit = (low_ones(width_bits(w_i)) >> 1) + 64'd1;
    for (int oi = 0; oi < 3; oi++) begin
      v = rand64();
      send_item(mops[oi], w_i, alu_flag_pkg::z, rand64(), v | sbit, rand_flags(), 1'b0);
      send_item(mops[oi], w_i, alu_flag_pkg::z, rand64(), v & ~sbit, rand_flags(), 1'b0);
    end
  end
  drain();
endtask

task automatic cond_codes();
  alu_op_pkg::alu_op_t op_i;
  for (int ci = 0; ci < 18; ci++) begin
    for (int oi = 0; oi < 2; oi++) begin
      if (oi == 0) op_i = alu_op_pkg::op_cmov;
      else op_i = alu_op_pkg::op_cset;
      for (int k = 0; k < n_flag_sets; k++) begin
        send_item(op_i, alu_op_pkg::width_t'(next_rand() % 32'd4),
                  alu_flag_pkg::cond_t'(ci), rand64(), rand64(), rand_flags(), 1'b0);
      end
    end
  end
  drain();
endtask

task automatic mixed_stream();
  logic [31:0] r1;
  logic [31:0] r2;
  send_item(alu_op_pkg::op_lahf, alu_op_pkg::w8, alu_flag_pkg::z, rand64(), rand64(),
            6'h2d, 1'b0);
  send_item(alu_op_pkg::op_sahf, alu_op_pkg::w8, alu_flag_pkg::z, 64'hffff_0000_0000_0015,
            rand64(), 6'h2a, 1'b0);
  for (int k = 0; k < n_stream; k++) begin
    r1 = next_rand();
    r2 = next_rand();
    send_item(alu_op_pkg::alu_op_t'(r1[31:24] % 8'd12), alu_op_pkg::width_t'(r1[23:22]),
              alu_flag_pkg::cond_t'(r2[31:24] % 8'd18), rand64(), rand64(), rand_flags(),
              r2[23:21] == 3'd0);
  end
  drain();
endtask

`endif

// File: tests/alu_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_top_tb;

  localparam int dw = alu_op_pkg::data_w;
  localparam int fw = alu_flag_pkg::flags_w;

  localparam int n_corner     = 7;
  localparam int n_rand_arith = 8;
  localparam int n_rand_logic = 4;
  localparam int n_flag_sets  = 4;
  localparam int n_stream     = 200;

  localparam int total_items = 1 + 8 * (n_corner + n_rand_arith) + 12 * n_rand_logic + 3
                               + 24 + 36 * n_flag_sets + 2 + n_stream;
  localparam int watchdog_ns = (total_items * 10 + 200) * 10;

  typedef struct packed {
    logic [dw-1:0] res;
    logic [fw-1:0] flags;
    logic          wr;
  } expect_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  in_valid;
  alu_op_pkg::alu_op_t   op;
  alu_op_pkg::width_t    width;
  alu_flag_pkg::cond_t   cond;
  logic [dw-1:0]         src_a;
  logic [dw-1:0]         src_b;
  logic [fw-1:0]         flags_in;
  logic                  keep_flags;
  logic                  out_valid;
  logic [dw-1:0]         result;
  logic [fw-1:0]         flags_out;
  logic                  flags_wr;

  logic [31:0] lcg_state = 32'h89c6_ecad;
  expect_t     exp_q[$];
  int          issue_q[$];  // cycle each item was presented
  int          cyc = 0;
  int          value_errs = 0;
  int          other_errs = 0;

  alu_top alu_top_inst (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .op         (op),
    .width      (width),
    .cond       (cond),
    .src_a      (src_a),
    .src_b      (src_b),
    .flags_in   (flags_in),
    .keep_flags (keep_flags),
    .out_valid  (out_valid),
    .result     (result),
    .flags_out  (flags_out),
    .flags_wr   (flags_wr)
  );

  always #5 clk = ~clk;

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function logic [dw-1:0] rand64();
    return {next_rand(), next_rand()};
  endfunction

  function logic [fw-1:0] rand_flags();
    logic [31:0] r;
    r = next_rand();
    return r[27:22];
  endfunction

  function automatic int width_bits(alu_op_pkg::width_t w);
    case (w)
      alu_op_pkg::w8:  return 8;
      alu_op_pkg::w16: return 16;
      alu_op_pkg::w32: return 32;
      default:         return 64;
    endcase
  endfunction

  function automatic logic [dw-1:0] low_ones(int bits);
    if (bits >= dw) return '1;
    return (64'd1 << bits) - 64'd1;
  endfunction

  function automatic logic [fw-1:0] flag_word(logic c, logic o, logic a, logic s, logic z,
                                              logic p);
    logic [fw-1:0] f;
    f[alu_flag_pkg::flag_c] = c;
    f[alu_flag_pkg::flag_o] = o;
    f[alu_flag_pkg::flag_a] = a;
    f[alu_flag_pkg::flag_s] = s;
    f[alu_flag_pkg::flag_z] = z;
    f[alu_flag_pkg::flag_p] = p;
    return f;
  endfunction

  // x86 jcc table
  function automatic logic cond_holds(logic [fw-1:0] f, alu_flag_pkg::cond_t c_i);
    logic cf, of, sf, zf, pf;
    cf = f[alu_flag_pkg::flag_c];
    of = f[alu_flag_pkg::flag_o];
    sf = f[alu_flag_pkg::flag_s];
    zf = f[alu_flag_pkg::flag_z];
    pf = f[alu_flag_pkg::flag_p];
    case (c_i)
      alu_flag_pkg::z:     return zf == 1'b1;
      alu_flag_pkg::nz:    return zf == 1'b0;
      alu_flag_pkg::s:     return sf == 1'b1;
      alu_flag_pkg::ns:    return sf == 1'b0;
      alu_flag_pkg::ugt:   return cf == 1'b0 && zf == 1'b0;
      alu_flag_pkg::ule:   return cf == 1'b1 || zf == 1'b1;
      alu_flag_pkg::uge:   return cf == 1'b0;
      alu_flag_pkg::ult:   return cf == 1'b1;
      alu_flag_pkg::sgt:   return zf == 1'b0 && sf == of;
      alu_flag_pkg::sle:   return zf == 1'b1 || sf != of;
      alu_flag_pkg::sge:   return sf == of;
      alu_flag_pkg::slt:   return sf != of;
      alu_flag_pkg::o:     return of == 1'b1;
      alu_flag_pkg::no:    return of == 1'b0;
      alu_flag_pkg::p:     return pf == 1'b1;
      alu_flag_pkg::np:    return pf == 1'b0;
      alu_flag_pkg::never: return 1'b0;
      default:             return 1'b1;
    endcase
  endfunction

  function automatic expect_t model_item(alu_op_pkg::alu_op_t op_i, alu_op_pkg::width_t w_i,
                                         alu_flag_pkg::cond_t c_i, logic [dw-1:0] a,
                                         logic [dw-1:0] b, logic [fw-1:0] f, logic keep);
    expect_t     e;
    int          n;
    logic [dw-1:0] m;
    logic [dw:0]   full;
    logic        sa, sb, sr, cy, ov, ax, zf, pf;
    n = width_bits(w_i);
    m = low_ones(n);
    sa = a[n-1];
    sb = b[n-1];
    cy = 1'b0;
    ax = 1'b0;
    e.res = '0;
    e.flags = f;
    e.wr = 1'b0;
    case (op_i)
      alu_op_pkg::op_add: begin
        full = {1'b0, a & m} + {1'b0, b & m};
        e.res = full[dw-1:0] & m;
        cy = full[n];
        ax = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
      end
      alu_op_pkg::op_sub: begin
        e.res = ((a & m) - (b & m)) & m;
        cy = (a & m) < (b & m);  // borrow
        ax = a[3:0] < b[3:0];
      end
      alu_op_pkg::op_and: e.res = a & b & m;
      alu_op_pkg::op_or:  e.res = (a | b) & m;
      alu_op_pkg::op_xor: e.res = (a ^ b) & m;
      alu_op_pkg::op_sxt: e.res = b[n-1] ? ((b & m) | ~m) : (b & m);
      alu_op_pkg::op_cmov: e.res = cond_holds(f, c_i) ? b : a;
      alu_op_pkg::op_cset: e.res = cond_holds(f, c_i) ? 64'd1 : 64'd0;
      alu_op_pkg::op_lahf: e.res = 64'(f);
      alu_op_pkg::op_sahf: e.flags = a[fw-1:0];
      default: e.res = b & m;  // mov, zxt
    endcase
    sr = e.res[n-1];
    zf = (e.res == '0);
    pf = ($countones(e.res[7:0]) % 2) == 0;
    if (op_i == alu_op_pkg::op_add) begin
      ov = (sa == sb) && (sr != sa);
      e.flags = flag_word(cy, ov, ax, sr, zf, pf);
    end else if (op_i == alu_op_pkg::op_sub) begin
      ov = (sa != sb) && (sr != sa);
      e.flags = flag_word(cy, ov, ax, sr, zf, pf);
    end else if (op_i inside {alu_op_pkg::op_and, alu_op_pkg::op_or, alu_op_pkg::op_xor}) begin
      e.flags = flag_word(1'b0, 1'b0, 1'b0, sr, zf, pf);
    end
    e.wr = !keep && (op_i inside {alu_op_pkg::op_add, alu_op_pkg::op_sub, alu_op_pkg::op_and,
                                  alu_op_pkg::op_or, alu_op_pkg::op_xor, alu_op_pkg::op_sahf});
    return e;
  endfunction

  task automatic send_item(input alu_op_pkg::alu_op_t op_i, input alu_op_pkg::width_t w_i,
                           input alu_flag_pkg::cond_t c_i, input logic [dw-1:0] a,
                           input logic [dw-1:0] b, input logic [fw-1:0] f, input logic keep);
    @(posedge clk);
    in_valid   <= 1'b1;
    op         <= op_i;
    width      <= w_i;
    cond       <= c_i;
    src_a      <= a;
    src_b      <= b;
    flags_in   <= f;
    keep_flags <= keep;
    exp_q.push_back(model_item(op_i, w_i, c_i, a, b, f, keep));
  endtask

  // idle the input and wait for everything in flight
  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_q.size() != 0 && waited < 8) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d items never came out of the pipeline", exp_q.size());
      other_errs++;
      exp_q.delete();
      issue_q.delete();
    end
  endtask

  task automatic check_output();
    expect_t e;
    int      issued;
    if (exp_q.size() == 0 || issue_q.size() == 0) begin
      $display("out_valid went high with no item in flight");
      other_errs++;
      return;
    end
    e = exp_q.pop_front();
    issued = issue_q.pop_front();
    assert (cyc - issued == 3) else begin
      $display("output came %0d cycles after its input instead of 3", cyc - issued);
      other_errs++;
    end
    assert (result === e.res) else begin
      $display("Fail result: expected %h, got %h", e.res, result);
      value_errs++;
    end
    assert (flags_out === e.flags) else begin
      $display("Fail flags_out: expected %h, got %h", e.flags, flags_out);
      value_errs++;
    end
    assert (flags_wr === e.wr) else begin
      $display("Fail flags_wr: expected %h, got %h", e.wr, flags_wr);
      value_errs++;
    end
  endtask

  // outputs are sampled mid-cycle
  always @(negedge clk) begin
    if (rst) begin
      cyc = 0;
    end else begin
      cyc++;
      if (in_valid) issue_q.push_back(cyc);
      if (out_valid) begin
        check_output();
      end else begin
        assert (flags_wr !== 1'b1) else begin
          $display("flags_wr went high without out_valid");
          other_errs++;
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    op         = alu_op_pkg::op_add;
    width      = alu_op_pkg::w64;
    cond       = alu_flag_pkg::z;
    src_a      = '0;
    src_b      = '0;
    flags_in   = '0;
    keep_flags = 1'b0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    idle_and_latency();
    add_sub_corners();
    logic_ops();
    moves_and_extends();
    cond_codes();
    mixed_stream();
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  `include "alu_tests.svh"

endmodule

`default_nettype wire

// File: alu_top.f
+incdir+tests
logic/alu_op_pkg.sv
logic/alu_flag_pkg.sv
logic/alu_decode.sv
logic/alu_cond.sv
logic/alu_execute.sv
logic/alu_result.sv
logic/alu_top.sv
tests/alu_top_tb.sv

// File: Makefile
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = alu_top_tb
FILELIST   = alu_top.f
OBJ_DIR    = obj_dir
PASS_MSG   = TEST RESULT: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
